// ==== hdl/island_pkg.sv ====
// Island window at address 0 with two 256-word banks and one control page and every other address errors
package island_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned BankNumWords = 256;
  localparam int unsigned BankIdxWidth = $clog2(BankNumWords);

  // --------------------
  // Address map
  // --------------------
  localparam logic [AddrWidth-1:0] PeriphOffset = 32'h0020_0000;
  localparam logic [AddrWidth-1:0] SocCtrlSize  = 32'h0000_1000;
  localparam int unsigned          CtrlIdxWidth = $clog2(SocCtrlSize) - 2;

  // Region codes as seen in address bits [22:21]
  localparam logic [1:0] MemRegion    = 2'd0;
  localparam logic [1:0] PeriphRegion = PeriphOffset[22:21];

  localparam logic [DataWidth-1:0] ErrorRdata    = 32'hBADC_AB1E;
  localparam logic [DataWidth-1:0] BootAddrReset = 32'h0000_0000;

  // Byte offsets inside the control page
  localparam logic [CtrlIdxWidth+1:0] RegFetchEn  = 12'h000;
  localparam logic [CtrlIdxWidth+1:0] RegBootAddr = 12'h004;

  typedef enum logic [1:0] {
    Default   = 2'd0,
    Jtag      = 2'd1,
    Preloaded = 2'd2
  } bootmode_e;

  // Same address word, split for the banks or for the control page
  typedef union packed {
    struct packed {
      logic [8:0]              tag;
      logic [1:0]              region;
      logic [9:0]              gap;
      logic                    bank;
      logic [BankIdxWidth-1:0] word_idx;
      logic [1:0]              byte_off;
    } mem;
    struct packed {
      logic [8:0]              tag;
      logic [1:0]              region;
      logic [8:0]              page;
      logic [CtrlIdxWidth-1:0] reg_idx;
      logic [1:0]              byte_off;
    } periph;
  } island_addr_u;

endpackage

// ==== hdl/island_apb_port.sv ====
// APB completer for one outstanding transfer that always inserts one wait state
module island_apb_port import island_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // APB completer side
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [AddrWidth-1:0] paddr_i,
  input  logic [DataWidth-1:0] pwdata_i,
  input  logic [StrbWidth-1:0] pstrb_i,
  output logic [DataWidth-1:0] prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,

  // Memory-style request side
  output logic                 req_o,
  output logic                 we_o,
  output logic [StrbWidth-1:0] be_o,
  output logic [AddrWidth-1:0] addr_o,
  output logic [DataWidth-1:0] wdata_o,
  input  logic                 rvalid_i,
  input  logic [DataWidth-1:0] rdata_i,
  input  logic                 err_i
);

  logic access;
  logic pending_q;

  assign access = psel_i & penable_i;

  // One request on entry to the access phase
  assign req_o   = access & ~pending_q;
  assign we_o    = pwrite_i;
  assign addr_o  = paddr_i;
  assign wdata_o = pwdata_i;
  // Reads fetch the full word
  assign be_o    = pwrite_i ? pstrb_i : '1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (req_o) begin
      pending_q <= 1'b1;
    end else if (rvalid_i) begin
      pending_q <= 1'b0;
    end
  end

  // --------------------
  // APB response
  // --------------------
  assign pready_o  = rvalid_i;
  assign pslverr_o = rvalid_i & err_i;

  always_comb begin
    prdata_o = '0;
    if (rvalid_i && !pwrite_i) begin
      prdata_o = rdata_i;
    end
  end

endmodule

// ==== hdl/island_router.sv ====
// Single requester decoder with a fixed one-cycle response and no stall path
module island_router import island_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // From the APB port
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [StrbWidth-1:0]         be_i,
  input  logic [AddrWidth-1:0]         addr_i,
  input  logic [DataWidth-1:0]         wdata_i,
  output logic                         rvalid_o,
  output logic [DataWidth-1:0]         rdata_o,
  output logic                         err_o,

  // To the SRAM banks
  output logic [1:0]                   bank_req_o,
  output logic                         bank_we_o,
  output logic [StrbWidth-1:0]         bank_be_o,
  output logic [BankIdxWidth-1:0]      bank_idx_o,
  output logic [DataWidth-1:0]         bank_wdata_o,
  input  logic [1:0][DataWidth-1:0]    bank_rdata_i,

  // To the control registers
  output logic                         ctrl_req_o,
  output logic                         ctrl_we_o,
  output logic [StrbWidth-1:0]         ctrl_be_o,
  output logic [CtrlIdxWidth-1:0]      ctrl_idx_o,
  output logic [DataWidth-1:0]         ctrl_wdata_o,
  input  logic [DataWidth-1:0]         ctrl_rdata_i
);

  island_addr_u addr;
  logic         in_window;
  logic         mem_hit;
  logic [1:0]   sel_bank;
  logic         sel_ctrl;
  logic         sel_err;

  logic [1:0]           bank_q;
  logic                 ctrl_q;
  logic                 err_q;
  logic                 rvalid_q;
  logic [DataWidth-1:0] ctrl_rdata_q;

  // --------------------
  // Address decode
  // --------------------
  assign addr      = addr_i;
  assign in_window = (addr.mem.tag == '0);
  assign mem_hit   = in_window && (addr.mem.region == MemRegion) && (addr.mem.gap == '0);
  assign sel_bank  = {mem_hit & addr.mem.bank, mem_hit & ~addr.mem.bank};
  assign sel_ctrl  = in_window && (addr.periph.region == PeriphRegion) &&
                     (addr.periph.page == '0);
  // Everything else falls to the error responder, writes there are dropped
  assign sel_err   = ~mem_hit & ~sel_ctrl;

  assign bank_req_o   = {2{req_i}} & sel_bank;
  assign bank_we_o    = we_i;
  assign bank_be_o    = be_i;
  assign bank_idx_o   = addr.mem.word_idx;
  assign bank_wdata_o = wdata_i;

  assign ctrl_req_o   = req_i & sel_ctrl;
  assign ctrl_we_o    = we_i;
  assign ctrl_be_o    = be_i;
  assign ctrl_idx_o   = addr.periph.reg_idx;
  assign ctrl_wdata_o = wdata_i;

  // --------------------
  // Response stage
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      bank_q   <= '0;
      ctrl_q   <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      bank_q   <= bank_req_o;
      ctrl_q   <= ctrl_req_o;
      err_q    <= req_i & sel_err;
    end
  end

  // Control block answers combinationally
  always_ff @(posedge clk_i) begin
    if (ctrl_req_o) begin
      ctrl_rdata_q <= ctrl_rdata_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (err_q) begin
      rdata_o = ErrorRdata;
    end else if (ctrl_q) begin
      rdata_o = ctrl_rdata_q;
    end else if (bank_q[0]) begin
      rdata_o = bank_rdata_i[0];
    end else if (bank_q[1]) begin
      rdata_o = bank_rdata_i[1];
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

endmodule

// ==== hdl/island_mem_bank.sv ====
// Single-port bank with one-cycle read latency and no initial content
module island_mem_bank import island_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [StrbWidth-1:0]    be_i,
  input  logic [BankIdxWidth-1:0] idx_i,
  input  logic [DataWidth-1:0]    wdata_i,
  output logic [DataWidth-1:0]    rdata_o
);

  logic [DataWidth-1:0] mem_q [BankNumWords];
  logic [DataWidth-1:0] rdata_q;

  // Byte lanes under their enables
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[idx_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hdl/island_soc_ctrl.sv ====
// Two registers in one page and unmapped indices read as zero without an error
module island_soc_ctrl import island_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [StrbWidth-1:0]    be_i,
  input  logic [CtrlIdxWidth-1:0] idx_i,
  input  logic [DataWidth-1:0]    wdata_i,
  output logic [DataWidth-1:0]    rdata_o,

  input  bootmode_e               bootmode_i,
  output logic                    fetch_enable_o,
  output logic [DataWidth-1:0]    boot_addr_o
);

  logic                 fetch_en_q;
  logic [DataWidth-1:0] boot_addr_q;
  logic                 hit_fetch_en;
  logic                 hit_boot_addr;

  assign hit_fetch_en  = (idx_i == RegFetchEn[CtrlIdxWidth+1:2]);
  assign hit_boot_addr = (idx_i == RegBootAddr[CtrlIdxWidth+1:2]);

  // --------------------
  // Register writes
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q  <= 1'b0;
      boot_addr_q <= BootAddrReset;
    end else if (req_i && we_i) begin
      if (hit_fetch_en && be_i[0]) begin
        fetch_en_q <= wdata_i[0];
      end
      if (hit_boot_addr) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) begin
            boot_addr_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // --------------------
  // Readback
  // --------------------
  always_comb begin
    rdata_o = '0;
    if (hit_fetch_en) begin
      rdata_o[0] = fetch_en_q;
    end else if (hit_boot_addr) begin
      rdata_o = boot_addr_q;
    end
  end

  // JTAG boot lets the debugger start the core regardless of software
  assign fetch_enable_o = fetch_en_q | (bootmode_i == Jtag);
  assign boot_addr_o    = boot_addr_q;

endmodule

// ==== hdl/island_top.sv ====
// Island top with one APB requester and every transfer completing with one wait state
module island_top import island_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // APB
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [AddrWidth-1:0] paddr_i,
  input  logic [DataWidth-1:0] pwdata_i,
  input  logic [StrbWidth-1:0] pstrb_i,
  output logic [DataWidth-1:0] prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,

  // Boot control
  input  bootmode_e            bootmode_i,
  output logic                 fetch_enable_o,
  output logic [DataWidth-1:0] boot_addr_o
);

  // --------------------
  // Request link
  // --------------------
  logic                 req;
  logic                 we;
  logic [StrbWidth-1:0] be;
  logic [AddrWidth-1:0] addr;
  logic [DataWidth-1:0] wdata;
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;
  logic                 err;

  // Bank and control links
  logic [1:0]                bank_req;
  logic                      bank_we;
  logic [StrbWidth-1:0]      bank_be;
  logic [BankIdxWidth-1:0]   bank_idx;
  logic [DataWidth-1:0]      bank_wdata;
  logic [1:0][DataWidth-1:0] bank_rdata;

  logic                    ctrl_req;
  logic                    ctrl_we;
  logic [StrbWidth-1:0]    ctrl_be;
  logic [CtrlIdxWidth-1:0] ctrl_idx;
  logic [DataWidth-1:0]    ctrl_wdata;
  logic [DataWidth-1:0]    ctrl_rdata;

  island_apb_port u_apb_port (
    .clk_i,
    .rst_ni,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .pstrb_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .req_o    ( req    ),
    .we_o     ( we     ),
    .be_o     ( be     ),
    .addr_o   ( addr   ),
    .wdata_o  ( wdata  ),
    .rvalid_i ( rvalid ),
    .rdata_i  ( rdata  ),
    .err_i    ( err    )
  );

  island_router u_router (
    .clk_i,
    .rst_ni,
    .req_i        ( req        ),
    .we_i         ( we         ),
    .be_i         ( be         ),
    .addr_i       ( addr       ),
    .wdata_i      ( wdata      ),
    .rvalid_o     ( rvalid     ),
    .rdata_o      ( rdata      ),
    .err_o        ( err        ),
    .bank_req_o   ( bank_req   ),
    .bank_we_o    ( bank_we    ),
    .bank_be_o    ( bank_be    ),
    .bank_idx_o   ( bank_idx   ),
    .bank_wdata_o ( bank_wdata ),
    .bank_rdata_i ( bank_rdata ),
    .ctrl_req_o   ( ctrl_req   ),
    .ctrl_we_o    ( ctrl_we    ),
    .ctrl_be_o    ( ctrl_be    ),
    .ctrl_idx_o   ( ctrl_idx   ),
    .ctrl_wdata_o ( ctrl_wdata ),
    .ctrl_rdata_i ( ctrl_rdata )
  );

  // --------------------
  // Memories
  // --------------------
  island_mem_bank u_bank0 (
    .clk_i,
    .rst_ni,
    .req_i   ( bank_req[0]   ),
    .we_i    ( bank_we       ),
    .be_i    ( bank_be       ),
    .idx_i   ( bank_idx      ),
    .wdata_i ( bank_wdata    ),
    .rdata_o ( bank_rdata[0] )
  );

  island_mem_bank u_bank1 (
    .clk_i,
    .rst_ni,
    .req_i   ( bank_req[1]   ),
    .we_i    ( bank_we       ),
    .be_i    ( bank_be       ),
    .idx_i   ( bank_idx      ),
    .wdata_i ( bank_wdata    ),
    .rdata_o ( bank_rdata[1] )
  );

  island_soc_ctrl u_soc_ctrl (
    .clk_i,
    .rst_ni,
    .req_i          ( ctrl_req   ),
    .we_i           ( ctrl_we    ),
    .be_i           ( ctrl_be    ),
    .idx_i          ( ctrl_idx   ),
    .wdata_i        ( ctrl_wdata ),
    .rdata_o        ( ctrl_rdata ),
    .bootmode_i,
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

// ==== dv/island_asserts.sv ====
// Shadow model assumes one APB transfer at a time and that every bank word is written before it is read
module island_asserts import island_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 psel_i,
  input logic                 penable_i,
  input logic                 pwrite_i,
  input logic [AddrWidth-1:0] paddr_i,
  input logic [DataWidth-1:0] pwdata_i,
  input logic [StrbWidth-1:0] pstrb_i,
  input logic [DataWidth-1:0] prdata_i,
  input logic                 pready_i,
  input logic                 pslverr_i,
  input bootmode_e            bootmode_i,
  input logic                 fetch_enable_i,
  input logic [DataWidth-1:0] boot_addr_i
);
  timeunit 1ns;
  timeprecision 100ps;

  bit                   fail_seen;
  logic                 access;
  logic                 in_window;
  logic                 hit_bank;
  logic                 hit_ctrl;
  logic                 hit_err;
  logic                 hit_fetch_en;
  logic                 hit_boot_addr;
  logic [DataWidth-1:0] expected_word;
  logic [DataWidth-1:0] expected_ctrl;

  logic [DataWidth-1:0] shadow_mem [2][BankNumWords];
  logic                 shadow_fe;
  logic [DataWidth-1:0] shadow_boot;

  // --------------------
  // Address map
  // --------------------
  assign access        = psel_i && penable_i;
  assign in_window     = (paddr_i[31:23] == 9'd0);
  assign hit_bank      = in_window && (paddr_i[22:21] == 2'd0) && (paddr_i[20:11] == 10'd0);
  assign hit_ctrl      = in_window && (paddr_i[22:21] == 2'd1) && (paddr_i[20:12] == 9'd0);
  assign hit_err       = !hit_bank && !hit_ctrl;
  assign hit_fetch_en  = hit_ctrl && (paddr_i[11:2] == 10'd0);
  assign hit_boot_addr = hit_ctrl && (paddr_i[11:2] == 10'd1);

  assign expected_word = shadow_mem[paddr_i[10]][paddr_i[9:2]];
  // Unmapped control indices read as zero
  assign expected_ctrl = hit_boot_addr ? shadow_boot :
                         hit_fetch_en  ? {{(DataWidth-1){1'b0}}, shadow_fe} : '0;

  // --------------------
  // Shadow state
  // --------------------
  always_ff @(posedge clk_i) begin
    if (pready_i && pwrite_i && hit_bank) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (pstrb_i[b]) begin
          shadow_mem[paddr_i[10]][paddr_i[9:2]][8*b +: 8] <= pwdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_fe   <= 1'b0;
      shadow_boot <= BootAddrReset;
    end else if (pready_i && pwrite_i) begin
      if (hit_fetch_en && pstrb_i[0]) begin
        shadow_fe <= pwdata_i[0];
      end
      if (hit_boot_addr) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (pstrb_i[b]) begin
            shadow_boot[8*b +: 8] <= pwdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // --------------------
  // Checks
  // --------------------
  a_wait_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(access) |-> !pready_i)
    else begin
      fail_seen = 1'b1;
      $error("Error at %0t: pready high in the first access cycle", $time);
    end

  a_ready_second: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(access) |=> pready_i)
    else begin
      fail_seen = 1'b1;
      $error("Error at %0t: pready missing in the second access cycle", $time);
    end

  a_ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_i |=> !pready_i)
    else begin
      fail_seen = 1'b1;
      $error("Error at %0t: pready held longer than one cycle", $time);
    end

  a_bank_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_i && hit_bank |-> !pslverr_i && (pwrite_i || prdata_i == expected_word))
    else begin
      fail_seen = 1'b1;
      $error("Error at %0t: bank access at %h read %h, expected %h", $time,
             paddr_i, prdata_i, expected_word);
    end

  a_error_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_i && hit_err |-> pslverr_i && (pwrite_i || prdata_i == ErrorRdata))
    else begin
      fail_seen = 1'b1;
      $error("Error at %0t: no error response at %h, read %h", $time, paddr_i, prdata_i);
    end

  a_ctrl_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_i && hit_ctrl |-> !pslverr_i && (pwrite_i || prdata_i == expected_ctrl))
    else begin
      fail_seen = 1'b1;
      $error("Error at %0t: control read at %h gave %h, expected %h", $time,
             paddr_i, prdata_i, expected_ctrl);
    end

  // Registers change at the request edge, so compare only outside the access phase
  a_boot_outputs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !access |-> boot_addr_i == shadow_boot &&
                fetch_enable_i == (shadow_fe || bootmode_i == Jtag))
    else begin
      fail_seen = 1'b1;
      $error("Error at %0t: boot_addr %h fetch_enable %b, expected %h %b", $time,
             boot_addr_i, fetch_enable_i, shadow_boot, shadow_fe || bootmode_i == Jtag);
    end

  a_reset_state: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !pready_i && !pslverr_i && boot_addr_i == BootAddrReset)
    else begin
      fail_seen = 1'b1;
      $error("Error at %0t: outputs not in reset state, boot_addr %h", $time, boot_addr_i);
    end

endmodule

bind island_top island_asserts u_asserts (
  .clk_i,
  .rst_ni,
  .psel_i,
  .penable_i,
  .pwrite_i,
  .paddr_i,
  .pwdata_i,
  .pstrb_i,
  .prdata_i       ( prdata_o       ),
  .pready_i       ( pready_o       ),
  .pslverr_i      ( pslverr_o      ),
  .bootmode_i,
  .fetch_enable_i ( fetch_enable_o ),
  .boot_addr_i    ( boot_addr_o    )
);

// ==== dv/island_tb.sv ====
// Bank traffic stays in the low 16 words of each bank, which are all written before any read
module island_tb import island_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ClkPeriod     = 40;
  localparam int unsigned DriveDelay    = 2;
  localparam int unsigned NumWords      = 16;
  localparam int unsigned NumRandom     = 140;
  localparam int unsigned MaxTransfers  = 200;
  localparam int unsigned CyclesPerXfer = 3;
  // Reset and end of test fit in the margin
  localparam int unsigned WatchdogNs    = (MaxTransfers * CyclesPerXfer + 40) * ClkPeriod;

  logic                 clk;
  logic                 rst_n;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [AddrWidth-1:0] paddr;
  logic [DataWidth-1:0] pwdata;
  logic [StrbWidth-1:0] pstrb;
  logic [DataWidth-1:0] prdata;
  logic                 pready;
  logic                 pslverr;
  bootmode_e            bootmode;
  logic                 fetch_enable;
  logic [DataWidth-1:0] boot_addr;
  logic [31:0]          lcg_state;
  logic                 assert_failed;

  island_top dut_i (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .psel_i         ( psel         ),
    .penable_i      ( penable      ),
    .pwrite_i       ( pwrite       ),
    .paddr_i        ( paddr        ),
    .pwdata_i       ( pwdata       ),
    .pstrb_i        ( pstrb        ),
    .prdata_o       ( prdata       ),
    .pready_o       ( pready       ),
    .pslverr_o      ( pslverr      ),
    .bootmode_i     ( bootmode     ),
    .fetch_enable_o ( fetch_enable ),
    .boot_addr_o    ( boot_addr    )
  );

  assign assert_failed = dut_i.u_asserts.fail_seen;

  initial begin
    clk = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] bank_addr(input logic bank, input logic [3:0] idx);
    return {21'd0, bank, 4'd0, idx, 2'd0};
  endfunction

  function automatic logic [31:0] ctrl_addr(input logic [11:0] offset);
    return PeriphOffset | {20'd0, offset};
  endfunction

  // Aliases tracked bank words so that dropped writes would show up on later reads
  function automatic logic [31:0] error_addr(input logic [31:0] r);
    logic [31:0] base;
    base = bank_addr(r[4], r[3:0]);
    case (r[12:11])
      2'd0: return base | {11'd0, r[22:13] | 10'd1, 11'd0};
      2'd1: return base | {r[21:13] | 9'd1, 23'd0};
      2'd2: return {9'd0, 2'd1, r[21:13] | 9'd1, 8'd0, r[1:0], 2'd0};
      default: return {9'd0, 1'b1, r[13], base[20:0]};
    endcase
  endfunction

  task automatic drive_idle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
  endtask

  // Starts 2 ns after an edge and returns 2 ns after the pready edge
  task automatic apb_transfer(input logic write, input logic [AddrWidth-1:0] addr,
                              input logic [DataWidth-1:0] data,
                              input logic [StrbWidth-1:0] strb);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = write ? data : '0;
    pstrb   = write ? strb : '0;
    @(posedge clk);
    #(DriveDelay);
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #(DriveDelay);
    drive_idle();
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] a;
    lcg_state = 32'h592f;
    bootmode  = Default;
    drive_idle();
    rst_n = 1'b1;
    #1;
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #(DriveDelay);
    rst_n = 1'b1;

    // --------------------
    // Fill tracked bank words
    // --------------------
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < NumWords; i++) begin
        a = bank_addr(1'(b), 4'(i));
        apb_transfer(1'b1, a, (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C, 4'hF);
      end
    end

    // Control registers and boot mode override
    apb_transfer(1'b0, ctrl_addr(RegBootAddr), '0, '0);
    apb_transfer(1'b0, ctrl_addr(RegFetchEn), '0, '0);
    // Unmapped index in the control page
    apb_transfer(1'b1, ctrl_addr(12'h008), 32'hFFFF_FFFF, 4'hF);
    apb_transfer(1'b0, ctrl_addr(12'h008), '0, '0);
    apb_transfer(1'b1, ctrl_addr(RegBootAddr), 32'h0000_0400, 4'hF);
    apb_transfer(1'b1, ctrl_addr(RegFetchEn), 32'h0000_0001, 4'h1);
    bootmode = Jtag;
    apb_transfer(1'b1, ctrl_addr(RegFetchEn), 32'h0000_0000, 4'h1);
    apb_transfer(1'b0, ctrl_addr(RegFetchEn), '0, '0);
    bootmode = Preloaded;
    apb_transfer(1'b1, ctrl_addr(RegBootAddr), 32'hFFFF_FFFF, 4'h6);
    apb_transfer(1'b0, ctrl_addr(RegBootAddr), '0, '0);

    // --------------------
    // Random traffic
    // --------------------
    for (int n = 0; n < NumRandom; n++) begin
      r = next_random();
      d = next_random();
      a = bank_addr(r[4], r[3:0]);
      case (r[31:29])
        3'd0, 3'd1, 3'd2: apb_transfer(1'b0, a, '0, '0);
        3'd3, 3'd4: apb_transfer(1'b1, a, d, r[8:5]);
        3'd5: apb_transfer(r[9], ctrl_addr(r[10] ? RegBootAddr : RegFetchEn), d, r[8:5]);
        3'd6: apb_transfer(r[9], error_addr(r), d, r[8:5]);
        default: begin
          case (r[1:0])
            2'd0: bootmode = Default;
            2'd1: bootmode = Jtag;
            default: bootmode = Preloaded;
          endcase
          apb_transfer(1'b0, a, '0, '0);
        end
      endcase
    end

    repeat (2) @(posedge clk);
    if (assert_failed) begin
      $display("Simulation finished: FAIL");
      $fatal(1, "Assertion failures were reported");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  // Stop at the first failing assertion
  initial begin
    wait (assert_failed);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first assertion failure");
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the test did not finish within %0d ns", WatchdogNs);
    $display("Simulation finished: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== files.f ====
hdl/island_pkg.sv
hdl/island_apb_port.sv
hdl/island_router.sv
hdl/island_mem_bank.sv
hdl/island_soc_ctrl.sv
hdl/island_top.sv
dv/island_asserts.sv
dv/island_tb.sv

// ==== Makefile ====
# Verilator flow for the island testbench

VERILATOR ?= verilator
TB_TOP    ?= island_tb
RTL_TOP   ?= island_top
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
SIM_ARGS  ?= +verilator+error+limit+10

SRCS     := $(shell grep -v '^+' $(FILE_LIST))
RTL_SRCS := $(filter hdl/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(FILE_LIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

sim: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
